//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_decode_stage
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
verilog/decode_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/issue_stage.sv
verilog/decode_stage.sv
tests/decode_checker.sv
tests/decode_assert.sv
tests/tb_decode_stage.sv

//--- tests/decode_assert.sv
// issue stage assertions: reset state, credit use on issue and credit bound
`default_nettype none

module decode_assert #(
    parameter int credits = 2
) (
    input logic                           clk,
    input logic                           reset,
    input logic                           credit_return,
    input logic                           out_valid,
    input logic [$clog2(credits + 1)-1:0] credit_cnt
);
    timeunit 1ns;
    timeprecision 100ps;

    // reset empties the output and refills every credit
    reset_state: assert property (@(posedge clk)
        reset |=> (!out_valid && credit_cnt == credits))
        else $error("output valid or credit count wrong after reset");

    // nothing issues out of an empty credit pool
    issue_has_credit: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> $past(credit_cnt) != '0)
        else $error("instruction issued with no credit left");

    // issue without a return spends exactly one credit
    issue_spends_credit: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !$past(credit_return)) |-> credit_cnt == $past(credit_cnt) - 1)
        else $error("credit count did not drop by one on issue");

    credit_bound: assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= credits)
        else $error("credit count above the execute buffer depth");

endmodule

bind issue_stage decode_assert #(
    .credits (credits)
) u_assert (
    .clk           (clk),
    .reset         (reset),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .credit_cnt    (credit_cnt)
);

`default_nettype wire

//--- tests/decode_checker.sv
// decode stage checker: compares stall each cycle and each issued packet with the table
`default_nettype none

module decode_checker (
    input  logic               clk,
    input  logic               reset,
    input  logic               stall,
    input  logic               out_valid,
    input  decode_pkg::issue_t out,
    output int                 tests_done,
    output int                 errors
);
    timeunit 1ns;
    timeprecision 100ps;

    // expectation of one row while it moves through the stage
    typedef struct {
        bit                   active;
        string                name;
        logic                 stall;
        logic                 issue;
        decode_pkg::xdata_t   pc;
        logic [31:0]          instr;
        decode_pkg::reg_idx_t rd;
        logic                 writes_rd;
        decode_pkg::xdata_t   imm;
        decode_pkg::xdata_t   rs1;
        decode_pkg::xdata_t   rs2;
        int                   errs;
    } row_expect_t;

    // cur is the row on the inputs, prv the one whose packet is due now
    row_expect_t cur;
    row_expect_t prv;

    initial begin
        tests_done = 0;
        errors = 0;
        cur.active = 1'b0;
        prv.active = 1'b0;
    end

    task automatic set_row(input string name, input logic st, input logic iss,
                           input decode_pkg::xdata_t pc, input logic [31:0] instr,
                           input decode_pkg::reg_idx_t rd, input logic wr,
                           input decode_pkg::xdata_t imm, input decode_pkg::xdata_t rs1,
                           input decode_pkg::xdata_t rs2);
        cur.active = 1'b1;
        cur.name = name;
        cur.stall = st;
        cur.issue = iss;
        cur.pc = pc;
        cur.instr = instr;
        cur.rd = rd;
        cur.writes_rd = wr;
        cur.imm = imm;
        cur.rs1 = rs1;
        cur.rs2 = rs2;
        cur.errs = 0;
    endtask

    function automatic int compare(input string test, input string field,
                                   input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Mismatch %s %s: expected %0h, actual %0h", test, field, exp, act);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge clk) begin
        if (!reset) begin
            // packet of the row consumed one edge ago
            if (prv.active) begin
                if (prv.issue && !out_valid) begin
                    $display("%s: expected issue did not appear at the output", prv.name);
                    prv.errs++;
                end else if (!prv.issue && out_valid) begin
                    $display("%s: an instruction issued that should not have", prv.name);
                    prv.errs++;
                end else if (out_valid) begin
                    prv.errs += compare(prv.name, "pc", prv.pc, out.pc);
                    prv.errs += compare(prv.name, "instr", 64'(prv.instr), 64'(out.instr));
                    prv.errs += compare(prv.name, "opcode", 64'(prv.instr[6:0]),
                                        64'(out.opcode));
                    // u and j formats have no funct3 field
                    if (!(prv.instr[6:0] inside {7'b0110111, 7'b0010111, 7'b1101111})) begin
                        prv.errs += compare(prv.name, "funct3", 64'(prv.instr[14:12]),
                                            64'(out.funct3));
                    end
                    prv.errs += compare(prv.name, "rd", 64'(prv.rd), 64'(out.rd));
                    prv.errs += compare(prv.name, "writes_rd", 64'(prv.writes_rd),
                                        64'(out.writes_rd));
                    prv.errs += compare(prv.name, "imm", prv.imm, out.imm);
                    prv.errs += compare(prv.name, "rs1_data", prv.rs1, out.rs1_data);
                    prv.errs += compare(prv.name, "rs2_data", prv.rs2, out.rs2_data);
                end
                errors += prv.errs;
                tests_done++;
                $display("%s: %s", prv.name, (prv.errs == 0) ? "ok" : "failed");
            end else if (out_valid) begin
                $display("an instruction issued while no test was running");
                errors++;
            end
            // stall of the row on the inputs now
            if (cur.active) begin
                cur.errs += compare(cur.name, "stall", 64'(cur.stall), 64'(stall));
            end
            prv = cur;
            cur.active = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_decode_stage.sv
// decode stage testbench: clock, reset, stimulus table, driving loop, watchdog and verdict
`default_nettype none

module tb_decode_stage;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int credits = 2;

    // one table row: drive values plus what the DUT should answer
    typedef struct {
        string                name;
        logic                 in_valid;
        logic                 flush;
        logic [31:0]          instr;
        decode_pkg::xdata_t   pc;
        decode_pkg::wb_t      wb;
        decode_pkg::pend_t    pend;
        logic                 credit_return;
        logic                 exp_stall;
        decode_pkg::reg_idx_t exp_rd;
        decode_pkg::xdata_t   exp_imm;
        decode_pkg::xdata_t   exp_rs1;
        decode_pkg::xdata_t   exp_rs2;
    } row_t;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    decode_pkg::xdata_t   pc;
    decode_pkg::instr_u   instr;
    logic                 flush;
    decode_pkg::wb_t      wb;
    decode_pkg::pend_t    pend;
    logic                 credit_return;
    logic                 stall;
    logic                 out_valid;
    decode_pkg::issue_t   out;
    int                   tests_done;
    int                   errors;

    row_t                 rows[$];
    // register contents as the table expects them
    decode_pkg::xdata_t   model[32];
    logic [63:0]          rng_state;
    bit                   table_ready;

    decode_stage #(
        .credits (credits)
    ) dut (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .pc            (pc),
        .instr         (instr),
        .flush         (flush),
        .stall         (stall),
        .wb            (wb),
        .pend          (pend),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out           (out)
    );

    decode_checker chk (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .out_valid  (out_valid),
        .out        (out),
        .tests_done (tests_done),
        .errors     (errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // xorshift64 for register data
    function automatic logic [63:0] next_rand();
        logic [63:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        rng_state = x;
        return x;
    endfunction

    // instruction encoders, immediates given at their natural width
    function automatic logic [31:0] enc_r(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic decode_pkg::wb_t write_back(input logic [4:0] rd, input logic [63:0] data);
        decode_pkg::wb_t w;
        w.valid = 1'b1;
        w.rd = rd;
        w.data = data;
        return w;
    endfunction

    function automatic decode_pkg::pend_t in_flight(input logic [4:0] rd);
        decode_pkg::pend_t p;
        p.valid = 1'b1;
        p.rd = rd;
        return p;
    endfunction

    task automatic add_row(input string name, input logic v, input logic fl,
                           input logic [31:0] ins, input decode_pkg::wb_t w,
                           input decode_pkg::pend_t p, input logic cr, input logic st,
                           input logic [4:0] rd, input logic [63:0] imm,
                           input logic [63:0] e1, input logic [63:0] e2);
        row_t r;
        r.name = name;
        r.in_valid = v;
        r.flush = fl;
        r.instr = ins;
        r.pc = 64'h8000_0000 + 64'(4 * rows.size());
        r.wb = w;
        r.pend = p;
        r.credit_return = cr;
        r.exp_stall = st;
        r.exp_rd = rd;
        r.exp_imm = imm;
        r.exp_rs1 = e1;
        r.exp_rs2 = e2;
        rows.push_back(r);
        // write lands at this row's edge, after its operands were read
        if (w.valid && w.rd != 5'd0) begin
            model[w.rd] = w.data;
        end
    endtask

    task automatic build_table();
        // every register reads zero out of reset
        for (int k = 0; k < 32; k += 2) begin
            add_row("reset_regs", 1, 0, enc_r(5'd1, 5'(k), 5'(k + 1)), '0, '0, 1, 0,
                    5'd1, '0, 64'd0, 64'd0);
        end
        // write-back then read, x0 stays zero, no same-cycle bypass
        add_row("wb_x3", 0, 0, '0, write_back(5'd3, next_rand()), '0, 0, 0, '0, '0, '0, '0);
        add_row("wb_x4", 0, 0, '0, write_back(5'd4, next_rand()), '0, 0, 0, '0, '0, '0, '0);
        add_row("wb_x0", 0, 0, '0, write_back(5'd0, next_rand()), '0, 0, 0, '0, '0, '0, '0);
        add_row("rr_read", 1, 0, enc_r(5'd7, 5'd3, 5'd4), '0, '0, 1, 0,
                5'd7, '0, model[3], model[4]);
        add_row("rr_x0", 1, 0, enc_r(5'd7, 5'd0, 5'd3), '0, '0, 1, 0, 5'd7, '0, 64'd0, model[3]);
        add_row("rr_no_bypass", 1, 0, enc_r(5'd7, 5'd4, 5'd3), write_back(5'd4, next_rand()),
                '0, 1, 0, 5'd7, '0, model[4], model[3]);
        add_row("rr_new_value", 1, 0, enc_r(5'd7, 5'd4, 5'd3), '0, '0, 1, 0,
                5'd7, '0, model[4], model[3]);
        // immediates per format, unused sources read as x0
        add_row("imm_i_neg", 1, 0, enc_i(7'b0010011, 5'd5, 5'd3, 12'hfff), '0, '0, 1, 0,
                5'd5, 64'hffff_ffff_ffff_ffff, model[3], 64'd0);
        add_row("imm_i_load", 1, 0, enc_i(7'b0000011, 5'd6, 5'd4, 12'h7ff), '0, '0, 1, 0,
                5'd6, 64'h7ff, model[4], 64'd0);
        add_row("imm_s_neg", 1, 0, enc_s(5'd3, 5'd4, 12'hff8), '0, '0, 1, 0,
                5'd0, 64'hffff_ffff_ffff_fff8, model[3], model[4]);
        add_row("imm_b_neg", 1, 0, enc_b(5'd4, 5'd3, 13'h1000), '0, '0, 1, 0,
                5'd0, 64'hffff_ffff_ffff_f000, model[4], model[3]);
        add_row("imm_b_pos", 1, 0, enc_b(5'd3, 5'd0, 13'h07fe), '0, '0, 1, 0,
                5'd0, 64'h7fe, model[3], 64'd0);
        add_row("imm_u_lui", 1, 0, enc_u(7'b0110111, 5'd8, 20'h80000), '0, '0, 1, 0,
                5'd8, 64'hffff_ffff_8000_0000, 64'd0, 64'd0);
        add_row("imm_u_auipc", 1, 0, enc_u(7'b0010111, 5'd9, 20'h12345), '0, '0, 1, 0,
                5'd9, 64'h1234_5000, 64'd0, 64'd0);
        add_row("imm_j_neg", 1, 0, enc_j(5'd1, 21'h1ffffe), '0, '0, 1, 0,
                5'd1, 64'hffff_ffff_ffff_fffe, 64'd0, 64'd0);
        add_row("imm_j_pos", 1, 0, enc_j(5'd1, 21'h0abcde), '0, '0, 1, 0,
                5'd1, 64'habcde, 64'd0, 64'd0);
        // hazards: held while pending, released once cleared
        add_row("hazard_rs2", 1, 0, enc_r(5'd10, 5'd3, 5'd4), '0, in_flight(5'd4), 0, 1,
                '0, '0, '0, '0);
        add_row("hazard_rs2", 1, 0, enc_r(5'd10, 5'd3, 5'd4), '0, '0, 1, 0,
                5'd10, '0, model[3], model[4]);
        add_row("pend_x0", 1, 0, enc_r(5'd11, 5'd0, 5'd4), '0, in_flight(5'd0), 1, 0,
                5'd11, '0, 64'd0, model[4]);
        add_row("hazard_rs1", 1, 0, enc_i(7'b0010011, 5'd12, 5'd3, 12'h004), '0,
                in_flight(5'd3), 0, 1, '0, '0, '0, '0);
        // imm low bits sit in the rs2 field, which this format does not read
        add_row("pend_unused", 1, 0, enc_i(7'b0010011, 5'd12, 5'd3, 12'h004), '0,
                in_flight(5'd4), 1, 0, 5'd12, 64'd4, model[3], 64'd0);
        // credits run out after two issues, one return frees the next
        add_row("credit_a", 1, 0, enc_r(5'd13, 5'd3, 5'd4), '0, '0, 0, 0,
                5'd13, '0, model[3], model[4]);
        add_row("credit_b", 1, 0, enc_r(5'd14, 5'd4, 5'd3), '0, '0, 0, 0,
                5'd14, '0, model[4], model[3]);
        add_row("credit_c_empty", 1, 0, enc_r(5'd15, 5'd3, 5'd3), '0, '0, 0, 1,
                '0, '0, '0, '0);
        add_row("credit_c_return", 1, 0, enc_r(5'd15, 5'd3, 5'd3), '0, '0, 1, 1,
                '0, '0, '0, '0);
        add_row("credit_c_issue", 1, 0, enc_r(5'd15, 5'd3, 5'd3), '0, '0, 0, 0,
                5'd15, '0, model[3], model[3]);
        add_row("credit_refill", 0, 0, '0, '0, '0, 1, 0, '0, '0, '0, '0);
        add_row("credit_refill", 0, 0, '0, '0, '0, 1, 0, '0, '0, '0, '0);
        // flushed input is dropped even against a hazard
        add_row("flush_hazard", 1, 1, enc_r(5'd16, 5'd3, 5'd4), '0, in_flight(5'd3), 0, 0,
                '0, '0, '0, '0);
        add_row("flush_plain", 1, 1, enc_i(7'b0010011, 5'd16, 5'd4, 12'h010), '0, '0, 0, 0,
                '0, '0, '0, '0);
        add_row("after_flush", 1, 0, enc_r(5'd17, 5'd4, 5'd3), '0, '0, 1, 0,
                5'd17, '0, model[4], model[3]);
    endtask

    // watchdog: row count plus reset and drain margin
    initial begin
        wait (table_ready);
        #((rows.size() + 30) * 8);
        $display("timeout: the run did not finish in the expected time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        flush = 1'b0;
        pc = '0;
        instr = '0;
        wb = '0;
        pend = '0;
        credit_return = 1'b0;
        rng_state = 64'd90364;
        table_ready = 1'b0;
        for (int k = 0; k < 32; k++) begin
            model[k] = '0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (rows[i]) begin
            in_valid = rows[i].in_valid;
            flush = rows[i].flush;
            pc = rows[i].pc;
            instr = rows[i].instr;
            wb = rows[i].wb;
            pend = rows[i].pend;
            credit_return = rows[i].credit_return;
            // every writer in the table names a nonzero rd
            chk.set_row(rows[i].name, rows[i].exp_stall,
                        rows[i].in_valid && !rows[i].flush && !rows[i].exp_stall,
                        rows[i].pc, rows[i].instr, rows[i].exp_rd,
                        rows[i].exp_rd != 5'd0, rows[i].exp_imm,
                        rows[i].exp_rs1, rows[i].exp_rs2);
            @(posedge clk);
            #1;
        end
        // idle while the last rows drain through the checker
        in_valid = 1'b0;
        flush = 1'b0;
        wb = '0;
        pend = '0;
        credit_return = 1'b0;
        wait (tests_done == rows.size());
        $display("tests run: %0d, errors: %0d", tests_done, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/decode_pkg.sv
// decode package: widths, opcode encodings, instruction formats and stage packets
`default_nettype none

package decode_pkg;

    // datapath and instruction widths
    localparam int xlen = 64;
    localparam int instr_w = 32;

    typedef logic [4:0] reg_idx_t;
    typedef logic [xlen-1:0] xdata_t;

    // rv64i major opcodes
    typedef enum logic [6:0] {
        op_r      = 7'b0110011,
        op_r_w    = 7'b0111011,
        op_jalr   = 7'b1100111,
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_imm_w  = 7'b0011011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_fence  = 7'b0001111,
        op_system = 7'b1110011
    } opcode_e;

    // register-register format
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // immediate format, also loads and jalr
    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // store format, immediate split around rs fields
    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch format, scrambled offset in halfwords
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    // upper immediate format
    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // jump format
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word seen through each format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    // decoder result
    typedef struct packed {
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic       uses_rs1;
        logic       uses_rs2;
        logic       writes_rd;
        opcode_e    opcode;
        logic [2:0] funct3;
        xdata_t     imm;
    } dec_t;

    // write-back port
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        xdata_t   data;
    } wb_t;

    // destination still in flight in execute
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
    } pend_t;

    // packet handed to execute
    typedef struct packed {
        xdata_t              pc;
        logic [instr_w-1:0]  instr;
        opcode_e             opcode;
        logic [2:0]          funct3;
        reg_idx_t            rd;
        logic                writes_rd;
        xdata_t              imm;
        xdata_t              rs1_data;
        xdata_t              rs2_data;
    } issue_t;

endpackage

`default_nettype wire

//--- verilog/decode_stage.sv
// decode stage top: decoder, register file and issue stage toward execute
`default_nettype none

module decode_stage #(
    parameter int credits = 2
) (
    input  logic                clk,
    input  logic                reset,
    // fetch side
    input  logic                in_valid,
    input  decode_pkg::xdata_t  pc,
    input  decode_pkg::instr_u  instr,
    input  logic                flush,
    output logic                stall,
    // write-back and in-flight destination
    input  decode_pkg::wb_t     wb,
    input  decode_pkg::pend_t   pend,
    // execute side
    input  logic                credit_return,
    output logic                out_valid,
    output decode_pkg::issue_t  out
);

    decode_pkg::dec_t   dec;
    decode_pkg::xdata_t rs1_data;
    decode_pkg::xdata_t rs2_data;

    instr_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    // operand read straight off the decoded indices
    reg_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    issue_stage #(
        .credits (credits)
    ) u_issue (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .flush         (flush),
        .pc            (pc),
        .instr         (instr),
        .dec           (dec),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .pend          (pend),
        .credit_return (credit_return),
        .stall         (stall),
        .out_valid     (out_valid),
        .out           (out)
    );

endmodule

`default_nettype wire

//--- verilog/instr_decoder.sv
// instruction decoder: field extraction, opcode class and sign-extended immediate
`default_nettype none

module instr_decoder (
    input  decode_pkg::instr_u instr,
    output decode_pkg::dec_t   dec
);

    decode_pkg::opcode_e op;
    logic                use1;
    logic                use2;
    logic                wr;
    decode_pkg::xdata_t  imm;

    // raw cast, unknown encodings fall to the default arm
    assign op = decode_pkg::opcode_e'(instr.r.opcode);

    always_comb begin
        use1 = 1'b0;
        use2 = 1'b0;
        wr = 1'b0;
        imm = '0;
        case (op)
            // register-register, no immediate
            decode_pkg::op_r, decode_pkg::op_r_w: begin
                use1 = 1'b1;
                use2 = 1'b1;
                wr = 1'b1;
            end
            decode_pkg::op_jalr, decode_pkg::op_load,
            decode_pkg::op_imm, decode_pkg::op_imm_w: begin
                use1 = 1'b1;
                wr = 1'b1;
                imm = {{(decode_pkg::xlen - 12){instr.i.imm[11]}}, instr.i.imm};
            end
            decode_pkg::op_store: begin
                use1 = 1'b1;
                use2 = 1'b1;
                imm = {{(decode_pkg::xlen - 12){instr.s.imm_hi[6]}},
                       instr.s.imm_hi, instr.s.imm_lo};
            end
            // branch offset, bit 0 always zero
            decode_pkg::op_branch: begin
                use1 = 1'b1;
                use2 = 1'b1;
                imm = {{(decode_pkg::xlen - 12){instr.b.imm_12}}, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            // upper 20 bits, low 12 zero
            decode_pkg::op_lui, decode_pkg::op_auipc: begin
                wr = 1'b1;
                imm = {{(decode_pkg::xlen - 32){instr.u.imm[19]}}, instr.u.imm, 12'b0};
            end
            decode_pkg::op_jal: begin
                wr = 1'b1;
                imm = {{(decode_pkg::xlen - 20){instr.j.imm_20}}, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            // fence, system and unknown: no register traffic
            default: begin
                use1 = 1'b0;
                use2 = 1'b0;
                wr = 1'b0;
            end
        endcase
    end

    // unused indices forced to x0 so the read data is a clean zero
    assign dec.rs1 = use1 ? instr.r.rs1 : '0;
    assign dec.rs2 = use2 ? instr.r.rs2 : '0;
    assign dec.rd = wr ? instr.r.rd : '0;
    assign dec.uses_rs1 = use1;
    assign dec.uses_rs2 = use2;
    assign dec.writes_rd = wr;
    assign dec.opcode = op;
    // u and j formats carry immediate bits where funct3 sits
    assign dec.funct3 = (op == decode_pkg::op_lui || op == decode_pkg::op_auipc ||
                         op == decode_pkg::op_jal) ? 3'b000 : instr.r.funct3;
    assign dec.imm = imm;

endmodule

`default_nettype wire

//--- verilog/issue_stage.sv
// issue stage: hazard stall, credit counting toward execute and the issue packet register
`default_nettype none

module issue_stage #(
    parameter int credits = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  logic                 flush,
    input  decode_pkg::xdata_t   pc,
    input  decode_pkg::instr_u   instr,
    input  decode_pkg::dec_t     dec,
    input  decode_pkg::xdata_t   rs1_data,
    input  decode_pkg::xdata_t   rs2_data,
    input  decode_pkg::pend_t    pend,
    input  logic                 credit_return,
    output logic                 stall,
    output logic                 out_valid,
    output decode_pkg::issue_t   out
);

    localparam int cnt_w = $clog2(credits + 1);

    logic [cnt_w-1:0] credit_cnt;
    logic             hazard;
    logic             no_credit;
    logic             fire;

    // pending result against a source this instruction really reads
    assign hazard = pend.valid && (pend.rd != '0) &&
                    ((dec.uses_rs1 && pend.rd == dec.rs1) ||
                     (dec.uses_rs2 && pend.rd == dec.rs2));
    assign no_credit = (credit_cnt == '0);

    // flushed input is swallowed as a bubble, never held
    assign stall = in_valid && !flush && (hazard || no_credit);
    assign fire = in_valid && !flush && !stall;

    // credits: spend on issue, refill on return, both may coincide
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= cnt_w'(credits);
        end else if (fire && !credit_return) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!fire && credit_return) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    // valid is a one-cycle pulse per issued instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= fire;
        end
    end

    // payload only loads on issue
    always_ff @(posedge clk) begin
        if (fire) begin
            out.pc <= pc;
            out.instr <= instr;
            out.opcode <= dec.opcode;
            out.funct3 <= dec.funct3;
            out.rd <= dec.rd;
            out.writes_rd <= dec.writes_rd;
            out.imm <= dec.imm;
            out.rs1_data <= rs1_data;
            out.rs2_data <= rs2_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
// register file: 32 x 64-bit, two async read ports, one write-back port, x0 reads zero
`default_nettype none

module reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  decode_pkg::reg_idx_t rs1,
    input  decode_pkg::reg_idx_t rs2,
    output decode_pkg::xdata_t   rs1_data,
    output decode_pkg::xdata_t   rs2_data,
    input  decode_pkg::wb_t      wb
);

    decode_pkg::xdata_t regs [32];

    // architectural state clears on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            // writes to x0 dropped
            regs[wb.rd] <= wb.data;
        end
    end

    // no write-through, a same-cycle write is seen next cycle
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire
